// File: Bender.yml
package:
  name: vend

export_include_dirs:
  - hw

sources:
  - hw/vend_pkg.sv
  - hw/stock_bus_if.sv
  - hw/sale_unit.sv
  - hw/restock_unit.sv
  - hw/stock_arbiter.sv
  - hw/stock_table.sv
  - hw/note_player.sv
  - hw/vend_top.sv
  - target: test
    files:
      - bench/vend_chk.sv
      - bench/vend_tb.sv

// File: bench/vend_chk.sv
`default_nettype none

module vend_chk (
    input logic                clk,
    input logic                rst,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input vend_pkg::prod_idx_t paddr,
    input vend_pkg::stock_t    pwdata,
    input logic [2:0]          note_played
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of assertion failures so far
    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////
    // table side of the stock bus
    ////////////////////////////////////////////////////////////

    // request held from setup through access
    bus_stable: assert property (@(posedge clk) disable iff (!rst)
        (psel && penable) |-> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else begin
            fail_cnt++;
            $error("stock bus request changed during an access");
        end

    // a transfer always opens with a setup cycle
    setup_first: assert property (@(posedge clk) disable iff (!rst)
        $rose(psel) |-> !penable)
        else begin
            fail_cnt++;
            $error("psel rose while penable was high");
        end

    enable_in_select: assert property (@(posedge clk) disable iff (!rst)
        penable |-> psel)
        else begin
            fail_cnt++;
            $error("penable high without psel");
        end

    // piezo has four steps only
    note_range: assert property (@(posedge clk) disable iff (!rst)
        note_played <= 3'd4)
        else begin
            fail_cnt++;
            $error("note_played above four");
        end

endmodule

// table_bus joins the arbiter to the table inside the top level
bind vend_top vend_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .psel        (table_bus.psel),
    .penable     (table_bus.penable),
    .pwrite      (table_bus.pwrite),
    .paddr       (table_bus.paddr),
    .pwdata      (table_bus.pwdata),
    .note_played (note_played)
);

`default_nettype wire

// File: bench/vend_tb.sv
`default_nettype none
`include "vend_cfg.svh"

module vend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import vend_pkg::*;

    localparam int n_tests    = 6;
    localparam int wait_limit = 20;

    logic        clk;
    logic        rst;
    logic [11:0] buttons;
    money_t      display_money;
    note_code_t  note_state;
    logic [2:0]  note_played;
    stock_t      prod_count_current;
    logic [2:0]  selected_item;
    logic        admin_mode;

    integer seed = 46574;
    // completed transfers on the table side
    int xfer_cnt;
    int exp_credit;

    vend_top UUT (
        .clk                (clk),
        .rst                (rst),
        .button_sw_oneshot  (buttons),
        .display_money      (display_money),
        .note_state         (note_state),
        .note_played        (note_played),
        .prod_count_current (prod_count_current),
        .selected_item      (selected_item),
        .admin_mode         (admin_mode)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst) begin
            xfer_cnt <= 0;
        end else if (UUT.table_bus.psel && UUT.table_bus.penable && UUT.table_bus.pready) begin
            xfer_cnt <= xfer_cnt + 1;
        end
    end

    // bound checker counts its assertion failures
    always @(posedge clk) begin
        if (UUT.u_chk.fail_cnt != 0) abort_run("stock bus or note assertion failed");
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // one-cycle pulse on a single button bit
    task automatic press_button(input int pos);
        @(posedge clk);
        buttons <= 12'd1 << pos;
        @(posedge clk);
        buttons <= '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_transfers(input int target);
        int waited;
        waited = 0;
        while (xfer_cnt < target) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) abort_run("stock bus transfer did not complete in time");
        end
        // count view trails a write by a cycle
        idle_cycles(2);
        @(negedge clk);
    endtask

    task automatic insert_coin(input int pos);
        int worth;
        case (pos)
            `VEND_BTN_COIN_10: worth = 10;
            `VEND_BTN_COIN_5:  worth = 5;
            default:           worth = 1;
        endcase
        if (exp_credit + worth <= `VEND_CREDIT_MAX) exp_credit = exp_credit + worth;
        press_button(pos);
        @(negedge clk);
        expect_value("display_money", display_money, exp_credit);
    endtask

    task automatic move_cursor(input int pos, input int exp_count);
        press_button(pos);
        idle_cycles(1);
        @(negedge clk);
        expect_value("prod_count_current", prod_count_current, exp_count);
    endtask

    task automatic select_product(input int exp_sel, input int n_xfer);
        int start;
        start = xfer_cnt;
        press_button(`VEND_BTN_SELECT);
        if (n_xfer > 0) wait_transfers(start + n_xfer);
        else @(negedge clk);
        expect_value("selected_item", selected_item, exp_sel);
    endtask

    task automatic buy_selected(input int n_xfer);
        int start;
        start = xfer_cnt;
        press_button(`VEND_BTN_BUY);
        wait_transfers(start + n_xfer);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic reset_values();
        expect_value("display_money", display_money, 0);
        expect_value("note_state", note_state, 0);
        expect_value("note_played", note_played, 0);
        expect_value("prod_count_current", prod_count_current, 9);
        expect_value("selected_item", selected_item, 0);
        expect_value("admin_mode", admin_mode, 0);
    endtask

    task automatic coin_credit();
        int pos;
        exp_credit = 0;
        repeat (24) begin
            pos = $unsigned($random(seed)) % 3;
            insert_coin(pos);
        end
        press_button(`VEND_BTN_RETURN);
        @(negedge clk);
        exp_credit = 0;
        expect_value("display_money", display_money, 0);
        // walk up to the ceiling and push past it
        repeat (10) insert_coin(`VEND_BTN_COIN_10);
        insert_coin(`VEND_BTN_COIN_5);
        repeat (5) insert_coin(`VEND_BTN_COIN_1);
        insert_coin(`VEND_BTN_COIN_5);
        press_button(`VEND_BTN_RETURN);
        @(negedge clk);
        exp_credit = 0;
        expect_value("display_money", display_money, 0);
    endtask

    task automatic cursor_moves();
        move_cursor(`VEND_BTN_UP, 9);
        move_cursor(`VEND_BTN_DOWN, 1);
        move_cursor(`VEND_BTN_DOWN, 0);
        move_cursor(`VEND_BTN_DOWN, 4);
        move_cursor(`VEND_BTN_DOWN, 4);
        move_cursor(`VEND_BTN_UP, 0);
        // product 3 is sold out
        select_product(0, 1);
        move_cursor(`VEND_BTN_UP, 1);
        select_product(2, 1);
        select_product(0, 0);
    endtask

    task automatic purchase_flow();
        insert_coin(`VEND_BTN_COIN_10);
        insert_coin(`VEND_BTN_COIN_5);
        select_product(2, 1);
        buy_selected(2);
        exp_credit = exp_credit - `VEND_PRICE_2;
        expect_value("display_money", display_money, exp_credit);
        expect_value("prod_count_current", prod_count_current, 0);
        expect_value("selected_item", selected_item, 0);
        expect_value("note_state", note_state, 9);
        move_cursor(`VEND_BTN_DOWN, 0);
        move_cursor(`VEND_BTN_DOWN, 4);
        select_product(4, 1);
        // short of credit so only a warning
        buy_selected(1);
        expect_value("display_money", display_money, exp_credit);
        expect_value("prod_count_current", prod_count_current, 4);
        expect_value("selected_item", selected_item, 0);
        expect_value("note_state", note_state, 12);
    endtask

    task automatic restock_admin();
        int start;
        int exp_stock;
        move_cursor(`VEND_BTN_UP, 0);
        start = xfer_cnt;
        press_button(`VEND_BTN_ADD);
        idle_cycles(10);
        @(negedge clk);
        expect_value("prod_count_current", prod_count_current, 0);
        expect_value("table bus transfers", xfer_cnt, start);
        press_button(`VEND_BTN_ADMIN);
        @(negedge clk);
        expect_value("admin_mode", admin_mode, 1);
        exp_stock = 0;
        repeat (10) begin
            start = xfer_cnt;
            press_button(`VEND_BTN_ADD);
            if (exp_stock < `VEND_STOCK_MAX) begin
                exp_stock++;
                wait_transfers(start + 2);
            end else begin
                wait_transfers(start + 1);
                // full shelf answers with the warning note
                expect_value("note_state", note_state, 12);
            end
            expect_value("prod_count_current", prod_count_current, exp_stock);
        end
        press_button(`VEND_BTN_ADMIN);
        @(negedge clk);
        expect_value("admin_mode", admin_mode, 0);
        press_button(`VEND_BTN_ADD);
        idle_cycles(10);
        @(negedge clk);
        expect_value("prod_count_current", prod_count_current, exp_stock);
    endtask

    task automatic note_sequence();
        int last;
        int held;
        int next;
        int cyc;
        bit done;
        idle_cycles(wait_limit);
        @(negedge clk);
        expect_value("note_played", note_played, 0);
        insert_coin(`VEND_BTN_COIN_1);
        last = 0;
        held = 0;
        done = 0;
        for (cyc = 0; cyc < 4 * `VEND_NOTE_STEP + 2 && !done; cyc++) begin
            @(negedge clk);
            if (note_played == last) begin
                held++;
            end else begin
                next = (last == 4) ? 0 : last + 1;
                expect_value("note_played", note_played, next);
                if (last != 0) expect_value("note step length", held, `VEND_NOTE_STEP);
                last = note_played;
                held = 1;
                if (next == 0) done = 1;
            end
            // coin of one unit plays code 1
            expect_value("note_state", note_state, (last == 0) ? 0 : 1);
        end
        if (!done) abort_run("note sequence did not return to idle in time");
    endtask

    initial begin
        rst     = 1'b0;
        buttons = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        reset_values();
        coin_credit();
        cursor_moves();
        purchase_flow();
        restock_admin();
        note_sequence();
        if (UUT.u_chk.fail_cnt != 0) begin
            abort_run("stock bus or note assertion failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    // watchdog with a generous budget per test
    initial begin
        repeat (n_tests * 200) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hw
hw/vend_pkg.sv
hw/stock_bus_if.sv
hw/sale_unit.sv
hw/restock_unit.sv
hw/stock_arbiter.sv
hw/stock_table.sv
hw/note_player.sv
hw/vend_top.sv
bench/vend_chk.sv
bench/vend_tb.sv

// File: hw/note_player.sv
`default_nettype none
`include "vend_cfg.svh"

module note_player (
    input  logic                 clk,
    input  logic                 rst,
    input  vend_pkg::note_code_t note_req,
    output vend_pkg::note_code_t note_state,
    output logic [2:0]           note_played
);

    localparam int step_w = $clog2(`VEND_NOTE_STEP + 1);

    logic [step_w-1:0] step_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            note_state  <= '0;
            note_played <= 3'd0;
            step_cnt    <= '0;
        end else if (note_req != '0) begin
            // new event restarts the melody
            note_state  <= note_req;
            note_played <= 3'd1;
            step_cnt    <= '0;
        end else if (note_played != 3'd0) begin
            if (step_cnt == step_w'(`VEND_NOTE_STEP - 1)) begin
                step_cnt <= '0;
                if (note_played == 3'd4) begin
                    note_played <= 3'd0;
                    note_state  <= '0;
                end else begin
                    note_played <= note_played + 3'd1;
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/restock_unit.sv
`default_nettype none
`include "vend_cfg.svh"

module restock_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [11:0]          buttons,
    input  vend_pkg::prod_idx_t  cursor,
    output logic                 admin_mode,
    output vend_pkg::note_code_t note_req,
    stock_bus_if.master          bus
);
    import vend_pkg::*;

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_rd_setup  = 3'd1;
    localparam logic [2:0] st_rd_access = 3'd2;
    localparam logic [2:0] st_wr_setup  = 3'd3;
    localparam logic [2:0] st_wr_access = 3'd4;

    logic [2:0] state;
    prod_idx_t  op_idx;
    stock_t     wr_data;

    assign bus.psel    = (state != st_idle);
    assign bus.penable = (state == st_rd_access) || (state == st_wr_access);
    assign bus.pwrite  = (state == st_wr_setup) || (state == st_wr_access);
    assign bus.paddr   = op_idx;
    assign bus.pwdata  = wr_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= st_idle;
            admin_mode <= 1'b0;
            note_req   <= note_none;
        end else begin
            note_req <= note_none;
            if (buttons[`VEND_BTN_ADMIN]) admin_mode <= ~admin_mode;
            case (state)
                st_idle: begin
                    // add only counts in admin mode
                    if (buttons[`VEND_BTN_ADD] && admin_mode) begin
                        op_idx <= cursor;
                        state  <= st_rd_setup;
                    end
                end
                st_rd_setup: state <= st_rd_access;
                st_rd_access: begin
                    if (bus.pready) begin
                        if (bus.prdata < stock_t'(`VEND_STOCK_MAX)) begin
                            wr_data <= bus.prdata + 4'd1;
                            state   <= st_wr_setup;
                        end else begin
                            // shelf already full
                            note_req <= note_warn;
                            state    <= st_idle;
                        end
                    end
                end
                st_wr_setup: state <= st_wr_access;
                st_wr_access: if (bus.pready) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/sale_unit.sv
`default_nettype none
`include "vend_cfg.svh"

module sale_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [11:0]          buttons,
    output vend_pkg::prod_idx_t  cursor,
    output vend_pkg::money_t     credit,
    output logic [2:0]           selected_item,
    output vend_pkg::note_code_t note_req,
    stock_bus_if.master          bus
);
    import vend_pkg::*;

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_rd_setup  = 3'd1;
    localparam logic [2:0] st_rd_access = 3'd2;
    localparam logic [2:0] st_wr_setup  = 3'd3;
    localparam logic [2:0] st_wr_access = 3'd4;

    logic [2:0] state;
    // 1 for a purchase, 0 for a select lookup
    logic       op_buy;
    prod_idx_t  op_idx;
    stock_t     wr_data;
    money_t     op_price;
    money_t     coin_val;
    note_code_t coin_note;
    logic       sel_hit;

    function automatic money_t price_of(prod_idx_t idx);
        case (idx)
            2'd0:    return money_t'(`VEND_PRICE_1);
            2'd1:    return money_t'(`VEND_PRICE_2);
            2'd2:    return money_t'(`VEND_PRICE_3);
            default: return money_t'(`VEND_PRICE_4);
        endcase
    endfunction

    function automatic note_code_t select_note(prod_idx_t idx);
        case (idx)
            2'd0:    return note_prod1;
            2'd1:    return note_prod2;
            2'd2:    return note_prod3;
            default: return note_prod4;
        endcase
    endfunction

    function automatic note_code_t buy_note(prod_idx_t idx);
        case (idx)
            2'd0:    return note_buy_prod1;
            2'd1:    return note_buy_prod2;
            2'd2:    return note_buy_prod3;
            default: return note_buy_prod4;
        endcase
    endfunction

    // largest coin wins if several bits are set
    always_comb begin
        if (buttons[`VEND_BTN_COIN_10]) begin
            coin_val  = 8'd10;
            coin_note = note_1000w;
        end else if (buttons[`VEND_BTN_COIN_5]) begin
            coin_val  = 8'd5;
            coin_note = note_500w;
        end else if (buttons[`VEND_BTN_COIN_1]) begin
            coin_val  = 8'd1;
            coin_note = note_100w;
        end else begin
            coin_val  = 8'd0;
            coin_note = note_none;
        end
    end

    assign op_price = price_of(op_idx);
    // select pressed again on the product already chosen
    assign sel_hit  = (selected_item != 3'd0) && (({1'b0, cursor} + 3'd1) == selected_item);

    assign bus.psel    = (state != st_idle);
    assign bus.penable = (state == st_rd_access) || (state == st_wr_access);
    assign bus.pwrite  = (state == st_wr_setup) || (state == st_wr_access);
    assign bus.paddr   = op_idx;
    assign bus.pwdata  = wr_data;

    ////////////////////////////////////////////////////////////
    // button handling and stock transfers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= st_idle;
            cursor        <= '0;
            credit        <= '0;
            selected_item <= '0;
            note_req      <= note_none;
        end else begin
            note_req <= note_none;
            case (state)
                st_idle: begin
                    if (buttons[`VEND_BTN_UP] || buttons[`VEND_BTN_DOWN]) begin
                        if (buttons[`VEND_BTN_UP]) begin
                            if (cursor != 2'd0) cursor <= cursor - 2'd1;
                        end else if (cursor != 2'd3) begin
                            cursor <= cursor + 2'd1;
                        end
                    end else if (buttons[`VEND_BTN_SELECT]) begin
                        if (sel_hit) begin
                            selected_item <= '0;
                        end else begin
                            op_buy <= 1'b0;
                            op_idx <= cursor;
                            state  <= st_rd_setup;
                        end
                    end else if (coin_val != '0) begin
                        if (credit + coin_val <= money_t'(`VEND_CREDIT_MAX)) begin
                            credit   <= credit + coin_val;
                            note_req <= coin_note;
                        end
                    end else if (buttons[`VEND_BTN_BUY]) begin
                        // nothing to buy without a selection
                        if (selected_item != 3'd0) begin
                            op_buy <= 1'b1;
                            op_idx <= prod_idx_t'(selected_item - 3'd1);
                            state  <= st_rd_setup;
                        end
                    end else if (buttons[`VEND_BTN_RETURN]) begin
                        credit <= '0;
                    end
                end
                st_rd_setup: state <= st_rd_access;
                st_rd_access: begin
                    if (bus.pready) begin
                        if (!op_buy) begin
                            if (bus.prdata != '0) begin
                                selected_item <= {1'b0, op_idx} + 3'd1;
                                note_req      <= select_note(op_idx);
                            end
                            state <= st_idle;
                        end else if (bus.prdata != '0 && credit >= op_price) begin
                            wr_data <= bus.prdata - 4'd1;
                            state   <= st_wr_setup;
                        end else begin
                            // sold out or short of credit
                            note_req      <= note_warn;
                            selected_item <= '0;
                            state         <= st_idle;
                        end
                    end
                end
                st_wr_setup: state <= st_wr_access;
                st_wr_access: begin
                    if (bus.pready) begin
                        credit        <= credit - op_price;
                        note_req      <= buy_note(op_idx);
                        selected_item <= '0;
                        state         <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/stock_arbiter.sv
`default_nettype none

module stock_arbiter (
    input  logic        clk,
    input  logic        rst,
    stock_bus_if.slave  m0,
    stock_bus_if.slave  m1,
    stock_bus_if.master s
);

    // grant is held for a whole transfer and m0 wins ties
    logic gnt_valid;
    logic gnt_m1;
    // slave side is past its setup cycle
    logic s_access;

    always_ff @(posedge clk) begin
        if (!rst) begin
            gnt_valid <= 1'b0;
            gnt_m1    <= 1'b0;
            s_access  <= 1'b0;
        end else if (!gnt_valid) begin
            if (m0.psel) begin
                gnt_valid <= 1'b1;
                gnt_m1    <= 1'b0;
            end else if (m1.psel) begin
                gnt_valid <= 1'b1;
                gnt_m1    <= 1'b1;
            end
        end else if (!s_access) begin
            s_access <= 1'b1;
        end else if (s.pready) begin
            gnt_valid <= 1'b0;
            s_access  <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // request path towards the table
    ////////////////////////////////////////////////////////////
    assign s.psel    = gnt_valid && (gnt_m1 ? m1.psel : m0.psel);
    assign s.penable = s_access;
    assign s.pwrite  = gnt_m1 ? m1.pwrite : m0.pwrite;
    assign s.paddr   = gnt_m1 ? m1.paddr : m0.paddr;
    assign s.pwdata  = gnt_m1 ? m1.pwdata : m0.pwdata;

    ////////////////////////////////////////////////////////////
    // response path back to the masters
    ////////////////////////////////////////////////////////////
    assign m0.prdata = s.prdata;
    assign m1.prdata = s.prdata;
    // ungranted master stays stalled
    assign m0.pready = gnt_valid && !gnt_m1 && s_access && s.pready;
    assign m1.pready = gnt_valid && gnt_m1 && s_access && s.pready;

endmodule

`default_nettype wire

// File: hw/stock_bus_if.sv
`default_nettype none

// APB-style access to the stock table
interface stock_bus_if;
    import vend_pkg::*;

    logic      psel;
    logic      penable;
    logic      pwrite;
    prod_idx_t paddr;
    stock_t    pwdata;
    stock_t    prdata;
    logic      pready;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

endinterface

`default_nettype wire

// File: hw/stock_table.sv
`default_nettype none
`include "vend_cfg.svh"

module stock_table (
    input  logic                clk,
    input  logic                rst,
    input  vend_pkg::prod_idx_t cursor,
    output vend_pkg::stock_t    count_at_cursor,
    stock_bus_if.slave          bus
);
    import vend_pkg::*;

    stock_t cnt [4];

    // zero wait states
    assign bus.pready = bus.psel && bus.penable;
    assign bus.prdata = cnt[bus.paddr];

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt[0]          <= stock_t'(`VEND_INIT_1);
            cnt[1]          <= stock_t'(`VEND_INIT_2);
            cnt[2]          <= stock_t'(`VEND_INIT_3);
            cnt[3]          <= stock_t'(`VEND_INIT_4);
            count_at_cursor <= stock_t'(`VEND_INIT_1);
        end else begin
            if (bus.psel && bus.penable && bus.pwrite) begin
                cnt[bus.paddr] <= bus.pwdata;
            end
            // view lags a write by one cycle
            count_at_cursor <= cnt[cursor];
        end
    end

endmodule

`default_nettype wire

// File: hw/vend_cfg.svh
`ifndef VEND_CFG_SVH
`define VEND_CFG_SVH

// product prices in 100-won units
`define VEND_PRICE_1 10
`define VEND_PRICE_2 12
`define VEND_PRICE_3 15
`define VEND_PRICE_4 18

// stock after reset
`define VEND_INIT_1 9
`define VEND_INIT_2 1
`define VEND_INIT_3 0
`define VEND_INIT_4 4

`define VEND_STOCK_MAX 9
`define VEND_CREDIT_MAX 99

// cycles per piezo step in simulation
`define VEND_NOTE_STEP 4

// bit positions in the one-shot button word
`define VEND_BTN_COIN_10 0
`define VEND_BTN_COIN_5 1
`define VEND_BTN_COIN_1 2
`define VEND_BTN_RETURN 3
`define VEND_BTN_DOWN 4
`define VEND_BTN_ADD 5
`define VEND_BTN_SELECT 7
`define VEND_BTN_BUY 9
`define VEND_BTN_UP 10
`define VEND_BTN_ADMIN 11

`endif

// File: hw/vend_pkg.sv
`default_nettype none

package vend_pkg;

    typedef logic [1:0] prod_idx_t;
    typedef logic [3:0] stock_t;
    // credit in 100-won units
    typedef logic [7:0] money_t;
    typedef logic [3:0] note_code_t;

    ////////////////////////////////////////////////////////////
    // piezo event codes
    ////////////////////////////////////////////////////////////
    localparam note_code_t note_none      = 4'd0;
    localparam note_code_t note_100w      = 4'd1;
    localparam note_code_t note_500w      = 4'd2;
    localparam note_code_t note_1000w     = 4'd3;
    localparam note_code_t note_prod1     = 4'd4;
    localparam note_code_t note_prod2     = 4'd5;
    localparam note_code_t note_prod3     = 4'd6;
    localparam note_code_t note_prod4     = 4'd7;
    localparam note_code_t note_buy_prod1 = 4'd8;
    localparam note_code_t note_buy_prod2 = 4'd9;
    localparam note_code_t note_buy_prod3 = 4'd10;
    localparam note_code_t note_buy_prod4 = 4'd11;
    localparam note_code_t note_warn      = 4'd12;

endpackage

`default_nettype wire

// File: hw/vend_top.sv
`default_nettype none

module vend_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [11:0]          button_sw_oneshot,
    output vend_pkg::money_t     display_money,
    output vend_pkg::note_code_t note_state,
    output logic [2:0]           note_played,
    output vend_pkg::stock_t     prod_count_current,
    output logic [2:0]           selected_item,
    output logic                 admin_mode
);
    import vend_pkg::*;

    prod_idx_t  cursor;
    note_code_t sale_note;
    note_code_t restock_note;
    note_code_t note_req;

    stock_bus_if sale_bus ();
    stock_bus_if restock_bus ();
    stock_bus_if table_bus ();

    sale_unit u_sale (
        .clk           (clk),
        .rst           (rst),
        .buttons       (button_sw_oneshot),
        .cursor        (cursor),
        .credit        (display_money),
        .selected_item (selected_item),
        .note_req      (sale_note),
        .bus           (sale_bus.master)
    );

    restock_unit u_restock (
        .clk        (clk),
        .rst        (rst),
        .buttons    (button_sw_oneshot),
        .cursor     (cursor),
        .admin_mode (admin_mode),
        .note_req   (restock_note),
        .bus        (restock_bus.master)
    );

    stock_arbiter u_arb (
        .clk (clk),
        .rst (rst),
        .m0  (sale_bus.slave),
        .m1  (restock_bus.slave),
        .s   (table_bus.master)
    );

    stock_table u_table (
        .clk             (clk),
        .rst             (rst),
        .cursor          (cursor),
        .count_at_cursor (prod_count_current),
        .bus             (table_bus.slave)
    );

    // sale events take the piezo first
    assign note_req = (sale_note != note_none) ? sale_note : restock_note;

    note_player u_note (
        .clk         (clk),
        .rst         (rst),
        .note_req    (note_req),
        .note_state  (note_state),
        .note_played (note_played)
    );

endmodule

`default_nettype wire
